/* list.f */
+incdir+hdl
hdl/spart_pkg.sv
hdl/baud_gen.sv
hdl/spart_rx.sv
hdl/spart_tx.sv
hdl/spart_top.sv
tests/tb_clock.sv
tests/spart_tb.sv

/* Makefile */
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

# testbench binary, assertions on
compile:
	verilator --binary --timing --assert -f list.f --top-module spart_tb \
		-Mdir $(BUILD) -o Vspart_tb

# pass only when the log holds the pass line
run: compile
	./$(BUILD)/Vspart_tb | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/spart_tb.sv */
`timescale 1ns/1ps
`include "spart_macros.svh"

module spart_tb;

   localparam int OVS = `SPART_OVERSAMPLE; // samples per bit
   localparam int SEED = 41491;
   localparam int LOOP_BYTES = 32;
   localparam int SLOW_BYTES = 16;
   localparam int HOLD_CYCLES = 200;
   localparam int RESET_TIMEOUT = 100; // cycles

   logic clk, rst_n;
   spart_pkg::baud_div_t baud_div;
   spart_pkg::data_t tx_data, rx_data;
   logic tx_valid, tx_ready, txd;
   logic rxd, rx_valid, rx_ready;

   logic loop_mode; // rxd follows txd when high
   logic rxd_drv; // line from the frame driver
   integer seed;
   int err_cnt, err_base, test_no, tests_failed;
   int rx_count; // bytes taken at the receive handshake
   int cyc; // free running cycle count
   int last_accept; // cycle of the latest transmit transfer
   spart_pkg::data_t exp_q[$]; // expected bytes in arrival order

   assign rxd = loop_mode ? txd : rxd_drv;

   tb_clock u_clock (.clk(clk), .rst_n(rst_n));

   spart_top DUT (
      .clk (clk),
      .rst_n (rst_n),
      .baud_div (baud_div),
      .tx_data (tx_data),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .txd (txd),
      .rxd (rxd),
      .rx_data (rx_data),
      .rx_valid (rx_valid),
      .rx_ready (rx_ready)
   );

   always @(posedge clk) cyc <= cyc + 1;

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   // frame in line order with the start bit in bit 0
   function automatic logic [9:0] make_frame(input logic [7:0] b);
      return {1'b1, b, 1'b0};
   endfunction

   // byte seen at rx_data for a frame
   // bit 8 flags that a byte is expected at all
   function automatic logic [8:0] expected_byte(input logic [9:0] frame,
                                                input int start_samples);
      logic [7:0] b;
      b = '0;
      if (frame[0] || start_samples < OVS / 2)
         return 9'h000; // start pulse under half a bit
      for (int i = 0; i < 8; i++)
         b[i] = frame[i + 1]; // lsb arrives first
      return {1'b1, b};
   endfunction

   function automatic int bit_cycles();
      return OVS * (int'(baud_div) + 1);
   endfunction

   ////////////////////////////////////////////////////////////
   // checking
   ////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("ERROR: timed out %s", what);
      err_cnt++;
   endtask

   // every receive transfer pops one expected byte
   task automatic compare_rx();
      spart_pkg::data_t exp_b;
      forever begin
         @(posedge clk);
         if (rst_n && rx_valid && rx_ready) begin
            if (exp_q.size() == 0) begin
               $display("ERROR: byte 0x%0h received when none was expected", rx_data);
               err_cnt++;
            end else begin
               exp_b = exp_q.pop_front();
               check_value("rx_data", 32'(exp_b), 32'(rx_data));
            end
            rx_count++;
         end
      end
   endtask

   task automatic end_test(input string name);
      test_no++;
      if (err_cnt != err_base) begin
         tests_failed++;
         $display("test %0d %s: %0d errors", test_no, name, err_cnt - err_base);
      end else begin
         $display("test %0d %s: ok", test_no, name);
      end
      err_base = err_cnt;
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus tasks start and end 1 ns after an edge
   ////////////////////////////////////////////////////////////
   task automatic drive_line(input logic value, input int samples);
      rxd_drv = value;
      repeat (samples * (int'(baud_div) + 1)) @(posedge clk);
      #1;
   endtask

   task automatic drive_frame(input logic [9:0] frame);
      for (int i = 0; i < 10; i++)
         drive_line(frame[i], OVS); // one bit time each
   endtask

   task automatic send_byte(input logic [7:0] b);
      logic [8:0] r;
      int n;
      r = expected_byte(make_frame(b), OVS);
      if (r[8])
         exp_q.push_back(r[7:0]);
      tx_data = b;
      tx_valid = 1'b1; // raised without looking at tx_ready
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!tx_ready && n < 2 * 10 * bit_cycles());
      if (tx_ready)
         last_accept = cyc; // transfer on this edge
      else
         report_timeout("waiting for tx_ready");
      #1;
      tx_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      int limit;
      n = 0;
      limit = (exp_q.size() + 2) * 10 * bit_cycles();
      do begin
         @(posedge clk);
         n++;
      end while (exp_q.size() != 0 && n < limit);
      if (exp_q.size() != 0)
         report_timeout("waiting for expected bytes at rx_data");
      #1;
   endtask

   task automatic wait_rx_valid();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!rx_valid && n < 4 * bit_cycles());
      if (!rx_valid)
         report_timeout("waiting for rx_valid");
      #1;
   endtask

   task automatic loopback_run(input int count);
      loop_mode = 1'b1;
      rx_ready = 1'b1;
      repeat (count) send_byte(8'($random(seed)));
      wait_drain();
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////
   initial begin
      int n;
      int rx_before;
      logic [7:0] b;
      logic [8:0] r;
      seed = SEED;
      baud_div = 16'd3;
      tx_data = '0;
      tx_valid = 1'b0;
      rx_ready = 1'b0;
      loop_mode = 1'b0;
      rxd_drv = 1'b1; // idle line
      fork
         compare_rx();
      join_none

      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!rst_n && n < RESET_TIMEOUT);
      if (!rst_n)
         report_timeout("waiting for reset release");
      repeat (5) begin
         @(posedge clk);
         check_value("txd", 1, 32'(txd));
         check_value("tx_ready", 1, 32'(tx_ready));
         check_value("rx_valid", 0, 32'(rx_valid));
         check_value("rx_data", 0, 32'(rx_data));
      end
      #1;
      end_test("reset state");

      loopback_run(LOOP_BYTES);
      end_test("loopback, baud_div 3");

      // second byte offered mid frame waits for the stop bit
      send_byte(8'($random(seed)));
      n = last_accept;
      repeat (20) @(posedge clk);
      #1;
      check_value("tx_ready", 0, 32'(tx_ready));
      send_byte(8'($random(seed)));
      n = last_accept - n;
      if (n < (10 * OVS - 1) * (int'(baud_div) + 1) || n > 10 * bit_cycles() + 2) begin
         $display("ERROR: second byte taken %0d cycles after the first", n);
         err_cnt++;
      end
      wait_drain();
      end_test("transmit back-pressure");

      // held byte with no consumer
      loop_mode = 1'b0;
      rx_ready = 1'b0;
      b = 8'($random(seed));
      r = expected_byte(make_frame(b), OVS);
      if (r[8])
         exp_q.push_back(r[7:0]);
      drive_frame(make_frame(b));
      wait_rx_valid();
      repeat (HOLD_CYCLES) begin
         @(posedge clk);
         check_value("rx_valid", 1, 32'(rx_valid));
         check_value("rx_data", 32'(r[7:0]), 32'(rx_data));
      end
      #1;
      rx_ready = 1'b1; // one accept
      @(posedge clk);
      #1;
      rx_ready = 1'b0;
      @(posedge clk);
      check_value("rx_valid", 0, 32'(rx_valid));
      check_value("pending bytes", 0, exp_q.size());
      #1;
      end_test("receive hold");

      // quarter bit low pulse followed by a real frame
      rx_ready = 1'b1;
      rx_before = rx_count;
      b = 8'($random(seed));
      r = expected_byte(make_frame(b), OVS / 4);
      if (r[8])
         exp_q.push_back(r[7:0]);
      drive_line(1'b0, OVS / 4);
      // idle longer than a whole frame
      // a byte started by the glitch would show up in here
      drive_line(1'b1, 10 * OVS);
      check_value("rx_count", rx_before, rx_count);
      check_value("rx_valid", 0, 32'(rx_valid));
      b = 8'($random(seed));
      r = expected_byte(make_frame(b), OVS);
      if (r[8])
         exp_q.push_back(r[7:0]);
      drive_frame(make_frame(b));
      wait_drain();
      end_test("glitch rejection");

      baud_div = 16'd9; // lands at the next counter wrap
      repeat (4) @(posedge clk);
      #1;
      loopback_run(SLOW_BYTES);
      end_test("loopback, baud_div 9");

      $display("tests %0d, failed %0d, errors %0d", test_no, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD = 4; // 8 ns clock
   localparam int RESET_CYCLES = 10;

   initial clk = 1'b0;
   always #(HALF_PERIOD) clk = ~clk;

   // reset low from time zero, released just after an edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

/* hdl/spart_top.sv */
`timescale 1ns/1ps

module spart_top (
   input logic clk,
   input logic rst_n,
   input spart_pkg::baud_div_t baud_div, // clocks per tick minus one, >= 1

   // transmit handshake and line
   input spart_pkg::data_t tx_data,
   input logic tx_valid,
   output logic tx_ready,
   output logic txd,

   // receive line and handshake
   input logic rxd,
   output spart_pkg::data_t rx_data,
   output logic rx_valid,
   input logic rx_ready
);

   logic baud_en; // shared 16x tick

   ////////////////////////////////////////////////////////////
   // baud generator
   ////////////////////////////////////////////////////////////
   baud_gen u_baud_gen (
      .clk (clk),
      .rst_n (rst_n),
      .baud_div (baud_div),
      .baud_en (baud_en)
   );

   ////////////////////////////////////////////////////////////
   // serial blocks
   ////////////////////////////////////////////////////////////
   spart_rx u_rx (
      .clk (clk),
      .rst_n (rst_n),
      .baud_en (baud_en),
      .rxd (rxd),
      .rx_data (rx_data),
      .rx_valid (rx_valid),
      .rx_ready (rx_ready)
   );

   spart_tx u_tx (
      .clk (clk),
      .rst_n (rst_n),
      .baud_en (baud_en),
      .tx_data (tx_data),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .txd (txd)
   );

endmodule

/* hdl/spart_tx.sv */
`timescale 1ns/1ps
`include "spart_macros.svh"

module spart_tx (
   input logic clk,
   input logic rst_n,
   input logic baud_en, // 16x oversampling tick
   input spart_pkg::data_t tx_data,
   input logic tx_valid,
   output logic tx_ready,
   output logic txd // registered serial line
);

   localparam int BIT_CNT_W = $clog2(`SPART_DATA_W);

   spart_pkg::tx_state_t state;
   spart_pkg::data_t shift; // bits still to send, lsb next
   spart_pkg::smpl_cnt_t smpl_cnt; // ticks within one symbol
   logic [BIT_CNT_W-1:0] bit_cnt;
   logic accept, sym_end;

   assign tx_ready = (state == spart_pkg::TX_IDLE);
   assign accept = tx_valid && tx_ready;
   // 16th tick of the symbol on txd
   assign sym_end = baud_en && (smpl_cnt == `SPART_OVERSAMPLE - 1);

   ////////////////////////////////////////////////////////////
   // frame state machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= spart_pkg::TX_IDLE;
         txd <= 1'b1; // line idles high
         smpl_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         if (state == spart_pkg::TX_IDLE || sym_end)
            smpl_cnt <= '0;
         else if (baud_en)
            smpl_cnt <= smpl_cnt + 1'b1;

         case (state)
            spart_pkg::TX_IDLE: begin
               bit_cnt <= '0;
               if (accept) begin
                  state <= spart_pkg::TX_START;
                  txd <= 1'b0; // start bit
               end
            end
            spart_pkg::TX_START: begin
               if (sym_end) begin
                  state <= spart_pkg::TX_DATA;
                  txd <= shift[0]; // bit 0
               end
            end
            spart_pkg::TX_DATA: begin
               if (sym_end) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == BIT_CNT_W'(`SPART_DATA_W - 1)) begin
                     state <= spart_pkg::TX_STOP;
                     txd <= 1'b1; // stop bit
                  end else begin
                     txd <= shift[0];
                  end
               end
            end
            spart_pkg::TX_STOP: begin
               if (sym_end)
                  state <= spart_pkg::TX_IDLE; // ready again next cycle
            end
            default: begin
               state <= spart_pkg::TX_IDLE;
               txd <= 1'b1;
            end
         endcase
      end
   end

   // payload shifter, loaded on accept
   always_ff @(posedge clk) begin
      if (accept)
         shift <= tx_data;
      else if (sym_end && state != spart_pkg::TX_STOP)
         shift <= shift >> 1; // next bit into lsb
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////
   a_idle_high: assert property (
      @(posedge clk) disable iff (!rst_n)
      state == spart_pkg::TX_IDLE |-> txd
   ) else $error("txd low while transmitter idle");

endmodule

/* hdl/spart_rx.sv */
`timescale 1ns/1ps
`include "spart_macros.svh"

module spart_rx (
   input logic clk,
   input logic rst_n,
   input logic baud_en, // 16x oversampling tick
   input logic rxd, // async serial line
   output spart_pkg::data_t rx_data, // held byte
   output logic rx_valid,
   input logic rx_ready
);

   localparam int BIT_CNT_W = $clog2(`SPART_DATA_W);

   logic rxd_meta, rxd_s; // synchronizer stages
   spart_pkg::rx_state_t state, state_next;
   spart_pkg::smpl_cnt_t smpl_cnt, mjr_cnt;
   logic [BIT_CNT_W-1:0] bit_cnt;

   logic smpl_clr, smpl_en;
   logic mjr_clr, mjr_en;
   logic bit_clr, bit_en;
   logic data_clr, data_en;
   logic rx_valid_next;
   logic vote; // majority result for current bit

   assign vote = (mjr_cnt >= `SPART_MAJORITY);

   ////////////////////////////////////////////////////////////
   // double flop synchronizer, idles high like the line
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_s <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_s <= rxd_meta;
      end
   end

   ////////////////////////////////////////////////////////////
   // sample, majority and bit counters
   ////////////////////////////////////////////////////////////

   // a clear may coincide with a tick, which then counts as sample 1
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         smpl_cnt <= '0;
      else if (smpl_clr)
         smpl_cnt <= smpl_en ? spart_pkg::smpl_cnt_t'(1) : '0;
      else if (smpl_en)
         smpl_cnt <= smpl_cnt + 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         mjr_cnt <= '0;
      else if (mjr_clr)
         mjr_cnt <= mjr_en ? spart_pkg::smpl_cnt_t'(1) : '0;
      else if (mjr_en)
         mjr_cnt <= mjr_cnt + 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         bit_cnt <= '0;
      else if (bit_clr)
         bit_cnt <= '0;
      else if (bit_en)
         bit_cnt <= bit_cnt + 1'b1; // wraps after bit 7
   end

   ////////////////////////////////////////////////////////////
   // held byte and valid flag
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rx_data <= '0;
      else if (data_clr)
         rx_data <= '0; // new frame confirmed
      else if (data_en)
         rx_data <= rx_data | (spart_pkg::data_t'(vote) << bit_cnt);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= spart_pkg::RX_IDLE;
         rx_valid <= 1'b0;
      end else begin
         state <= state_next;
         rx_valid <= rx_valid_next; // registered FIN flag
      end
   end

   ////////////////////////////////////////////////////////////
   // state decoder
   ////////////////////////////////////////////////////////////
   always_comb begin
      state_next = state;
      smpl_clr = 1'b0;
      smpl_en = 1'b0;
      mjr_clr = 1'b0;
      mjr_en = 1'b0;
      bit_clr = 1'b0;
      bit_en = 1'b0;
      data_clr = 1'b0;
      data_en = 1'b0;
      rx_valid_next = 1'b0;

      case (state)
         spart_pkg::RX_IDLE: begin
            smpl_clr = 1'b1;
            mjr_clr = 1'b1;
            if (!rxd_s)
               state_next = spart_pkg::RX_START; // possible start bit
         end

         spart_pkg::RX_START: begin
            if (smpl_cnt == `SPART_OVERSAMPLE) begin
               state_next = spart_pkg::RX_START_TEST;
            end else begin
               smpl_en = baud_en;
               mjr_en = baud_en & ~rxd_s; // count lows here
            end
         end

         spart_pkg::RX_START_TEST: begin
            smpl_clr = 1'b1;
            mjr_clr = 1'b1;
            if (mjr_cnt >= `SPART_MAJORITY) begin
               state_next = spart_pkg::RX_SAMPLE;
               data_clr = 1'b1;
               bit_clr = 1'b1;
               smpl_en = baud_en; // first sample of bit 0
               mjr_en = baud_en & rxd_s;
            end else begin
               state_next = spart_pkg::RX_IDLE; // glitch, drop it
            end
         end

         spart_pkg::RX_SAMPLE: begin
            if (smpl_cnt == `SPART_OVERSAMPLE) begin
               state_next = spart_pkg::RX_RECORD;
            end else begin
               smpl_en = baud_en;
               mjr_en = baud_en & rxd_s; // count highs
            end
         end

         spart_pkg::RX_RECORD: begin
            data_en = 1'b1;
            bit_en = 1'b1;
            smpl_clr = 1'b1;
            mjr_clr = 1'b1;
            if (bit_cnt == BIT_CNT_W'(`SPART_DATA_W - 1)) begin
               state_next = spart_pkg::RX_FIN; // stop bit not checked
            end else begin
               state_next = spart_pkg::RX_SAMPLE;
               smpl_en = baud_en;
               mjr_en = baud_en & rxd_s;
            end
         end

         spart_pkg::RX_FIN: begin
            rx_valid_next = 1'b1;
            if (rx_valid && rx_ready) begin
               rx_valid_next = 1'b0; // byte taken
               // a start bit already on the line goes straight on
               state_next = rxd_s ? spart_pkg::RX_IDLE : spart_pkg::RX_START;
            end
         end

         default: state_next = spart_pkg::RX_IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////
   a_rx_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_valid && !rx_ready |=> $stable(rx_data)
   ) else $error("rx_data changed while stalled");

   a_smpl_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      smpl_cnt <= `SPART_OVERSAMPLE
   ) else $error("sample counter above oversample count");

endmodule

/* hdl/baud_gen.sv */
`timescale 1ns/1ps

module baud_gen (
   input logic clk,
   input logic rst_n,
   input spart_pkg::baud_div_t baud_div, // reloaded on every wrap
   output logic baud_en // one cycle pulse, 16x bit rate
);

   spart_pkg::baud_div_t cnt; // down counter

   ////////////////////////////////////////////////////////////
   // divisor counter
   ////////////////////////////////////////////////////////////

   // period is baud_div + 1 clocks, so a new divisor
   // only lands at the next reload
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
         baud_en <= 1'b0;
      end else if (cnt == '0) begin
         cnt <= baud_div; // wrap
         baud_en <= 1'b1; // tick
      end else begin
         cnt <= cnt - 1'b1;
         baud_en <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // both serial blocks rely on a quiet cycle after each tick
   // to leave their 16th-sample states, needs baud_div >= 1
   a_baud_en_gap: assert property (
      @(posedge clk) disable iff (!rst_n)
      baud_en |=> !baud_en
   ) else $error("baud_en high on two consecutive cycles");

endmodule

/* hdl/spart_pkg.sv */
`include "spart_macros.svh"

package spart_pkg;

   ////////////////////////////////////////////////////////////
   // vector types
   ////////////////////////////////////////////////////////////

   typedef logic [`SPART_DATA_W-1:0] data_t; // one serial character
   typedef logic [`SPART_DIV_W-1:0] baud_div_t; // clocks per baud_en minus one

   // counts 0 to 16 samples so it needs one bit above the oversample range
   typedef logic [$clog2(`SPART_OVERSAMPLE + 1)-1:0] smpl_cnt_t;

   ////////////////////////////////////////////////////////////
   // state machines
   ////////////////////////////////////////////////////////////

   // receiver states
   typedef enum logic [2:0] {
      RX_IDLE, // wait for line low
      RX_START, // count low samples of start bit
      RX_START_TEST, // start bit or glitch
      RX_SAMPLE, // count high samples of a data bit
      RX_RECORD, // vote and store one bit
      RX_FIN // byte held until consumer takes it
   } rx_state_t;

   // transmitter states
   typedef enum logic [1:0] {
      TX_IDLE, // line high, ready for a byte
      TX_START, // start bit on txd
      TX_DATA, // eight data bits lsb first
      TX_STOP // stop bit
   } tx_state_t;

endpackage

/* hdl/spart_macros.svh */
`ifndef SPART_MACROS_SVH
`define SPART_MACROS_SVH

////////////////////////////////////////////////////////////
// serial character and baud divisor widths
////////////////////////////////////////////////////////////

`define SPART_DATA_W 8 // bits per character, 8N1 frame
`define SPART_DIV_W 16 // baud divisor width

////////////////////////////////////////////////////////////
// oversampling
////////////////////////////////////////////////////////////

`define SPART_OVERSAMPLE 16 // baud_en pulses per bit
`define SPART_MAJORITY 8 // high samples needed to vote a 1

`endif
